//--- Makefile
# Verilator simulation of the VGA scan-out engine
TOOL     := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := vga_tb
FILELIST := build.f
OBJ_DIR  := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

# A $$fatal in the testbench makes the run, and so this target, fail
test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
common/vga_pkg.sv
logic/vga_timing.sv
display/vram_fetch.sv
display/pixel_shifter.sv
logic/vga_output.sv
logic/vga_display_top.sv
verif/vga_tb.sv

//--- common/vga_pkg.sv
// VGA scan-out package with shared widths and scan and VRAM structs
`default_nettype none

package vga_pkg;

   //////////////////////////////////////////////////
   // Widths

   // Raster counters, both axes
   localparam int coord_w = 11;

   // VRAM word address
   localparam int vram_addr_w = 15;

   // VRAM word, also pixels per word
   localparam int vram_data_w = 32;

   //////////////////////////////////////////////////
   // Scan state, one word per pixel clock

   typedef struct packed {
      logic active;          // Visible area
      logic in_box;          // Frame buffer window
      logic in_border;       // One-pixel frame around the box
      logic hsync;           // High inside sync interval
      logic vsync;
      logic frame_start;     // First cycle of a frame
      logic box_word_start;  // First pixel of a 32-pixel group
   } scan_t;

   //////////////////////////////////////////////////
   // VRAM read traffic

   typedef struct packed {
      logic [vram_addr_w-1:0] addr;
   } vram_req_t;

   typedef struct packed {
      logic [vram_data_w-1:0] data;
   } vram_rsp_t;

endpackage

`default_nettype wire

//--- display/pixel_shifter.sv
// Pixel shifter, unpacks each VRAM word into 32 box pixels LSB first
`timescale 1ns/10ps
`default_nettype none

module pixel_shifter (
   input  wire                             vga_clk,
   input  wire                             reset,
   input  wire vga_pkg::scan_t             scan,
   input  wire                             word_valid,
   input  wire [vga_pkg::vram_data_w-1:0]  word_data,
   output logic                            word_ready,
   output logic                            pixel,
   output vga_pkg::scan_t                  scan_d,
   output logic                            underrun
);
   import vga_pkg::*;

   logic [vram_data_w-1:0] shift_q;
   logic [vram_data_w-1:0] load_word;

   //////////////////////////////////////////////////
   // Word pull

   // One word taken at the start of each group
   assign word_ready = scan.box_word_start;

   // Missing word shows as black
   assign load_word = word_valid ? word_data : '0;

   //////////////////////////////////////////////////
   // Pixel and scan alignment

   always_ff @(posedge vga_clk or posedge reset) begin
      if (reset) begin
         pixel    <= 1'b0;
         scan_d   <= '0;
         underrun <= 1'b0;
      end else begin
         // Same delay as pixel
         scan_d <= scan;
         if (scan.box_word_start) begin
            // First pixel of the group is bit 0
            pixel <= load_word[0];
            // Sticky until reset
            if (!word_valid)
               underrun <= 1'b1;
         end else begin
            pixel <= shift_q[0];
         end
      end
   end

   // Remaining bits move down one per pixel
   always_ff @(posedge vga_clk) begin
      if (scan.box_word_start)
         shift_q <= load_word >> 1;
      else
         shift_q <= shift_q >> 1;
   end

endmodule

`default_nettype wire

//--- display/vram_fetch.sv
// VRAM fetch engine, sequential word reads into a two-word prefetch buffer
`timescale 1ns/10ps
`default_nettype none

module vram_fetch (
   input  wire                              vga_clk,
   input  wire                              reset,
   input  wire                              frame_start,
   output logic                             vram_req_valid,
   output vga_pkg::vram_req_t               vram_req,
   input  wire                              vram_req_ready,
   input  wire                              vram_rsp_valid,
   input  wire vga_pkg::vram_rsp_t          vram_rsp,
   output logic                             word_valid,
   output logic [vga_pkg::vram_data_w-1:0]  word_data,
   input  wire                              word_ready
);
   import vga_pkg::*;

   logic [vram_data_w-1:0] word_buf [2];
   logic                   wr_ptr, rd_ptr;
   logic [1:0]             count;
   logic                   pending;
   logic                   drop;
   logic [vram_addr_w-1:0] next_addr;
   logic                   req_fire, rsp_keep, pop, launch;

   //////////////////////////////////////////////////
   // Handshakes

   assign req_fire = vram_req_valid && vram_req_ready;
   // Stale answers from the previous frame are thrown away
   assign rsp_keep = vram_rsp_valid && !drop && !frame_start;
   assign pop      = word_valid && word_ready;

   // Nothing in flight and room left for the answer
   assign launch = !vram_req_valid && !pending && (count != 2'd2) && !frame_start;

   assign word_valid = (count != 2'd0);
   assign word_data  = word_buf[rd_ptr];

   always_ff @(posedge vga_clk or posedge reset) begin
      if (reset) begin
         vram_req_valid <= 1'b0;
         pending        <= 1'b0;
         drop           <= 1'b0;
         count          <= 2'd0;
         wr_ptr         <= 1'b0;
         rd_ptr         <= 1'b0;
         next_addr      <= '0;
      end else begin
         // Valid held until the slave takes it
         if (launch)
            vram_req_valid <= 1'b1;
         else if (req_fire)
            vram_req_valid <= 1'b0;
         // One request outstanding
         if (req_fire)
            pending <= 1'b1;
         else if (vram_rsp_valid)
            pending <= 1'b0;
         // Mark whatever is still in flight at frame start
         if (frame_start)
            drop <= (pending && !vram_rsp_valid) || vram_req_valid;
         else if (vram_rsp_valid)
            drop <= 1'b0;
         // Buffer and address restart each frame
         if (frame_start) begin
            count     <= 2'd0;
            wr_ptr    <= 1'b0;
            rd_ptr    <= 1'b0;
            next_addr <= '0;
         end else begin
            if (rsp_keep)
               wr_ptr <= ~wr_ptr;
            if (pop)
               rd_ptr <= ~rd_ptr;
            count <= count + 2'(rsp_keep) - 2'(pop);
            if (launch)
               next_addr <= next_addr + 1'b1;
         end
      end
   end

   // Payload, qualified by count and valid
   always_ff @(posedge vga_clk) begin
      if (rsp_keep)
         word_buf[wr_ptr] <= vram_rsp.data;
      if (launch)
         vram_req.addr <= next_addr;
   end

endmodule

`default_nettype wire

//--- logic/vga_display_top.sv
// VGA display top, timing, VRAM fetch, pixel shifter and output stage
`timescale 1ns/10ps
`default_nettype none

module vga_display_top #(
   parameter int H_DISP     = 1280,
   parameter int H_FPORCH   = 16,
   parameter int H_SYNC     = 100,
   parameter int H_BPORCH   = 200,
   parameter int V_DISP     = 1024,
   parameter int V_FPORCH   = 1,
   parameter int V_SYNC     = 3,
   parameter int V_BPORCH   = 38,
   parameter int BOX_WIDTH  = 768,
   parameter int BOX_HEIGHT = 896
) (
   input  wire                      vga_clk,
   input  wire                      reset,
   output logic                     vram_req_valid,
   output vga_pkg::vram_req_t       vram_req,
   input  wire                      vram_req_ready,
   input  wire                      vram_rsp_valid,
   input  wire vga_pkg::vram_rsp_t  vram_rsp,
   output logic                     vga_r,
   output logic                     vga_g,
   output logic                     vga_b,
   output logic                     vga_hsync,
   output logic                     vga_vsync,
   output logic                     vga_blank,
   output logic                     underrun
);
   import vga_pkg::*;

   scan_t                  scan;
   scan_t                  scan_d;
   logic                   word_valid;
   logic [vram_data_w-1:0] word_data;
   logic                   word_ready;
   logic                   pixel;

   //////////////////////////////////////////////////
   // Raster timing

   vga_timing #(
      .H_DISP(H_DISP), .H_FPORCH(H_FPORCH), .H_SYNC(H_SYNC), .H_BPORCH(H_BPORCH),
      .V_DISP(V_DISP), .V_FPORCH(V_FPORCH), .V_SYNC(V_SYNC), .V_BPORCH(V_BPORCH),
      .BOX_WIDTH(BOX_WIDTH), .BOX_HEIGHT(BOX_HEIGHT)
   ) timing0 (
      .vga_clk(vga_clk), .reset(reset), .scan(scan)
   );

   //////////////////////////////////////////////////
   // Data path

   // Address restarts on each frame
   vram_fetch fetch0 (
      .vga_clk(vga_clk), .reset(reset), .frame_start(scan.frame_start),
      .vram_req_valid(vram_req_valid), .vram_req(vram_req),
      .vram_req_ready(vram_req_ready),
      .vram_rsp_valid(vram_rsp_valid), .vram_rsp(vram_rsp),
      .word_valid(word_valid), .word_data(word_data), .word_ready(word_ready)
   );

   pixel_shifter shifter0 (
      .vga_clk(vga_clk), .reset(reset), .scan(scan),
      .word_valid(word_valid), .word_data(word_data), .word_ready(word_ready),
      .pixel(pixel), .scan_d(scan_d), .underrun(underrun)
   );

   vga_output output0 (
      .vga_clk(vga_clk), .reset(reset), .scan_d(scan_d), .pixel(pixel),
      .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
      .vga_hsync(vga_hsync), .vga_vsync(vga_vsync), .vga_blank(vga_blank)
   );

endmodule

`default_nettype wire

//--- logic/vga_output.sv
// VGA output stage, registers color, syncs and blank for the pins
`timescale 1ns/10ps
`default_nettype none

module vga_output (
   input  wire             vga_clk,
   input  wire             reset,
   input  wire vga_pkg::scan_t scan_d,
   input  wire             pixel,
   output logic            vga_r,
   output logic            vga_g,
   output logic            vga_b,
   output logic            vga_hsync,
   output logic            vga_vsync,
   output logic            vga_blank
);
   import vga_pkg::*;

   logic  color;

   //////////////////////////////////////////////////
   // Pin registers

   always_ff @(posedge vga_clk or posedge reset) begin
      if (reset) begin
         color     <= 1'b0;
         vga_hsync <= 1'b1;
         vga_vsync <= 1'b1;
         vga_blank <= 1'b0;
      end else begin
         // Box pixel, border white, rest black
         color     <= scan_d.in_box ? pixel : scan_d.in_border;
         // Syncs are active low
         vga_hsync <= ~scan_d.hsync;
         vga_vsync <= ~scan_d.vsync;
         // Blank low outside the visible area
         vga_blank <= scan_d.active;
      end
   end

   // Monochrome, same bit on all guns
   assign vga_r = color;
   assign vga_g = color;
   assign vga_b = color;

endmodule

`default_nettype wire

//--- logic/vga_timing.sv
// VGA raster timing generator with sync, visible area, box and border decode
`timescale 1ns/10ps
`default_nettype none

module vga_timing #(
   parameter int H_DISP     = 1280,
   parameter int H_FPORCH   = 16,
   parameter int H_SYNC     = 100,
   parameter int H_BPORCH   = 200,
   parameter int V_DISP     = 1024,
   parameter int V_FPORCH   = 1,
   parameter int V_SYNC     = 3,
   parameter int V_BPORCH   = 38,
   parameter int BOX_WIDTH  = 768,
   parameter int BOX_HEIGHT = 896
) (
   input  wire             vga_clk,
   input  wire             reset,
   output vga_pkg::scan_t  scan
);
   import vga_pkg::*;

   // Total periods
   localparam int h_total = H_DISP + H_FPORCH + H_SYNC + H_BPORCH;
   localparam int v_total = V_DISP + V_FPORCH + V_SYNC + V_BPORCH;

   // Box centered in the visible area
   localparam int h_box_lo = (H_DISP - BOX_WIDTH) / 2;
   localparam int h_box_hi = h_box_lo + BOX_WIDTH;
   localparam int v_box_lo = (V_DISP - BOX_HEIGHT) / 2;
   localparam int v_box_hi = v_box_lo + BOX_HEIGHT;

   // Low column bits that pick a pixel inside one word
   localparam int word_bits = $clog2(vram_data_w);

   logic [coord_w-1:0] h_cnt;
   logic [coord_w-1:0] v_cnt;
   logic [coord_w-1:0] h_rel;
   logic               line_end;
   logic               h_box, v_box;
   logic               h_edge, v_edge;
   logic               h_span, v_span;
   scan_t              scan_nxt;

   //////////////////////////////////////////////////
   // Counters

   assign line_end = (h_cnt == coord_w'(h_total - 1));

   always_ff @(posedge vga_clk or posedge reset) begin
      if (reset) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else if (line_end) begin
         h_cnt <= '0;
         // Vertical steps once per line
         if (v_cnt == coord_w'(v_total - 1))
            v_cnt <= '0;
         else
            v_cnt <= v_cnt + 1'b1;
      end else begin
         h_cnt <= h_cnt + 1'b1;
      end
   end

   //////////////////////////////////////////////////
   // Decode

   assign h_box  = (h_cnt >= h_box_lo) && (h_cnt < h_box_hi);
   assign v_box  = (v_cnt >= v_box_lo) && (v_cnt < v_box_hi);

   // Column or row just outside the box
   assign h_edge = (int'(h_cnt) == h_box_lo - 1) || (h_cnt == h_box_hi);
   assign v_edge = (int'(v_cnt) == v_box_lo - 1) || (v_cnt == v_box_hi);

   // Box extent grown by one, so corners are covered
   assign h_span = (int'(h_cnt) >= h_box_lo - 1) && (h_cnt <= h_box_hi);
   assign v_span = (int'(v_cnt) >= v_box_lo - 1) && (v_cnt <= v_box_hi);

   // Column inside the box
   assign h_rel = h_cnt - coord_w'(h_box_lo);

   always_comb begin
      scan_nxt.active    = (h_cnt < H_DISP) && (v_cnt < V_DISP);
      scan_nxt.in_box    = scan_nxt.active && h_box && v_box;
      scan_nxt.in_border = scan_nxt.active && ((h_edge && v_span) || (v_edge && h_span));
      scan_nxt.hsync     = (h_cnt >= H_DISP + H_FPORCH) &&
                           (h_cnt < H_DISP + H_FPORCH + H_SYNC);
      scan_nxt.vsync     = (v_cnt >= V_DISP + V_FPORCH) &&
                           (v_cnt < V_DISP + V_FPORCH + V_SYNC);
      scan_nxt.frame_start    = (h_cnt == '0) && (v_cnt == '0);
      scan_nxt.box_word_start = scan_nxt.in_box && (h_rel[word_bits-1:0] == '0);
   end

   // Scan word one cycle behind the counters
   always_ff @(posedge vga_clk or posedge reset) begin
      if (reset)
         scan <= '0;
      else
         scan <= scan_nxt;
   end

endmodule

`default_nettype wire

//--- verif/vga_tb.sv
// Testbench for the VGA scan-out engine with a VRAM responder and a raster model
`timescale 1ns/10ps
`default_nettype none

module vga_tb;
   import vga_pkg::*;

   //////////////////////////////////////////////////
   // Small raster
   localparam int h_disp = 96;
   localparam int h_fporch = 4;
   localparam int h_sync = 8;
   localparam int h_bporch = 6;
   localparam int v_disp = 20;
   localparam int v_fporch = 1;
   localparam int v_sync = 2;
   localparam int v_bporch = 2;
   localparam int box_width = 64;
   localparam int box_height = 12;

   localparam int h_total = h_disp + h_fporch + h_sync + h_bporch;
   localparam int v_total = v_disp + v_fporch + v_sync + v_bporch;
   localparam int frame_cycles = h_total * v_total;
   // Box corners, centered
   localparam int h_box_lo = (h_disp - box_width) / 2;
   localparam int h_box_hi = h_box_lo + box_width;
   localparam int v_box_lo = (v_disp - box_height) / 2;
   localparam int v_box_hi = v_box_lo + box_height;

   localparam int clk_period = 10;
   localparam int reset_cycles = 5;
   localparam int frames_to_check = 3;
   // Plus one frame for the model to lock onto vsync
   localparam int timeout_cycles = reset_cycles + (frames_to_check + 1) * frame_cycles;

   logic vga_clk, reset;
   logic vram_req_valid, vram_req_ready, vram_rsp_valid;
   vram_req_t vram_req;
   vram_rsp_t vram_rsp;
   logic vga_r, vga_g, vga_b, vga_hsync, vga_vsync, vga_blank, underrun;

   // VRAM contents
   logic [vram_data_w-1:0] mem [0:(1 << vram_addr_w)-1];
   integer seed;

   // Responder state
   logic busy, fire, hold_pend;
   int wait_cnt;
   logic [vram_addr_w-1:0] rsp_addr, hold_addr;

   // Raster model state
   int col, row, cyc, last_hfall, last_vfall, vfalls;
   logic h_seen, v_seen, hsync_q, vsync_q;

   vga_display_top #(
      .H_DISP(h_disp), .H_FPORCH(h_fporch), .H_SYNC(h_sync), .H_BPORCH(h_bporch),
      .V_DISP(v_disp), .V_FPORCH(v_fporch), .V_SYNC(v_sync), .V_BPORCH(v_bporch),
      .BOX_WIDTH(box_width), .BOX_HEIGHT(box_height)
   ) dut0 (
      .vga_clk(vga_clk), .reset(reset),
      .vram_req_valid(vram_req_valid), .vram_req(vram_req),
      .vram_req_ready(vram_req_ready),
      .vram_rsp_valid(vram_rsp_valid), .vram_rsp(vram_rsp),
      .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
      .vga_hsync(vga_hsync), .vga_vsync(vga_vsync), .vga_blank(vga_blank),
      .underrun(underrun)
   );

   always #(clk_period / 2) vga_clk = ~vga_clk;

   task automatic check(input string name, input int expected, input int actual);
      if (expected != actual) begin
         $display("error %s expected %0d actual %0d", name, expected, actual);
         $display("sim failed");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   function automatic logic is_visible(input int c, input int r);
      return (c < h_disp) && (r < v_disp);
   endfunction

   // Ring one pixel wide around the box, corners included
   function automatic logic is_border(input int c, input int r);
      logic in_ring, inside_box;
      in_ring = (c >= h_box_lo - 1) && (c <= h_box_hi) &&
                (r >= v_box_lo - 1) && (r <= v_box_hi);
      inside_box = (c >= h_box_lo) && (c < h_box_hi) &&
                   (r >= v_box_lo) && (r < v_box_hi);
      return is_visible(c, r) && in_ring && !inside_box;
   endfunction

   // Box pixels LSB first, words in address order
   function automatic logic expected_color(input int c, input int r);
      int idx;
      logic [vram_data_w-1:0] data_word;
      if (c >= h_box_lo && c < h_box_hi && r >= v_box_lo && r < v_box_hi) begin
         idx = (r - v_box_lo) * box_width + (c - h_box_lo);
         data_word = mem[idx / vram_data_w];
         return data_word[idx % vram_data_w];
      end
      return is_border(c, r);
   endfunction

   //////////////////////////////////////////////////
   // Stimulus and run control
   initial begin
      seed = 37281;
      for (int i = 0; i < (1 << vram_addr_w); i++)
         mem[i] = $random(seed);
      vga_clk = 1'b0;
      reset = 1'b1;
      vram_req_ready = 1'b0;
      vram_rsp_valid = 1'b0;
      vram_rsp = '0;
      {col, row, cyc, last_hfall, last_vfall, vfalls} = '0;
      {h_seen, v_seen} = 2'b00;
      {hsync_q, vsync_q} = 2'b11;
      repeat (reset_cycles) @(posedge vga_clk);
      reset <= 1'b0;
      // First vsync locks the model, then full frames
      while (vfalls < frames_to_check + 1)
         @(posedge vga_clk);
      $display("sim passed");
      $finish;
   end

   // Watchdog
   initial begin
      #(timeout_cycles * clk_period);
      $display("timeout, %0d frames not seen in %0d cycles", frames_to_check, timeout_cycles);
      $display("sim failed");
      $fatal(1, "watchdog expired");
   end

   //////////////////////////////////////////////////
   // VRAM responder
   always @(posedge vga_clk) begin
      if (reset) begin
         vram_req_ready <= 1'b0;
         vram_rsp_valid <= 1'b0;
         busy = 1'b0;
         hold_pend = 1'b0;
      end else begin
         // Stalled request must hold
         if (hold_pend) begin
            check("req_valid_held", 1, vram_req_valid);
            check("req_addr_held", hold_addr, vram_req.addr);
         end
         hold_pend = vram_req_valid && !vram_req_ready;
         hold_addr = vram_req.addr;
         fire = vram_req_valid && vram_req_ready;
         if (fire)
            check("single_outstanding", 0, busy);
         vram_rsp_valid <= 1'b0;
         if (busy) begin
            wait_cnt = wait_cnt - 1;
            if (wait_cnt == 0) begin
               vram_rsp_valid <= 1'b1;
               vram_rsp.data <= mem[rsp_addr];
               busy = 1'b0;
            end
         end
         // Answer after 1 to 4 cycles
         if (fire) begin
            busy = 1'b1;
            rsp_addr = vram_req.addr;
            wait_cnt = 1 + ({$random(seed)} % 4);
         end
         // Ready about three cycles in four
         vram_req_ready <= ({$random(seed)} % 4) != 0;
      end
   end

   //////////////////////////////////////////////////
   // Raster model and pin checks, away from the active edge
   always @(negedge vga_clk) begin
      if (!reset) begin
         cyc = cyc + 1;
         col = (col + 1) % h_total;
         if (col == 0)
            row = (row + 1) % v_total;
         // Sync edges realign the model
         if (hsync_q && !vga_hsync) begin
            if (h_seen)
               check("hsync_period", h_total, cyc - last_hfall);
            h_seen = 1'b1;
            last_hfall = cyc;
            col = h_disp + h_fporch;
         end
         if (!hsync_q && vga_hsync && h_seen)
            check("hsync_width", h_sync, cyc - last_hfall);
         if (vsync_q && !vga_vsync) begin
            if (v_seen)
               check("vsync_period", v_total * h_total, cyc - last_vfall);
            v_seen = 1'b1;
            last_vfall = cyc;
            vfalls = vfalls + 1;
            row = v_disp + v_fporch;
         end
         if (!vsync_q && vga_vsync && v_seen)
            check("vsync_width", v_sync * h_total, cyc - last_vfall);
         if (h_seen && v_seen) begin
            check("blank", is_visible(col, row), vga_blank);
            check("color", {3{expected_color(col, row)}}, {vga_r, vga_g, vga_b});
         end
         check("underrun", 0, underrun);
         hsync_q = vga_hsync;
         vsync_q = vga_vsync;
      end
   end

endmodule

`default_nettype wire
